/* filelist.f */
verilog/arcade_io_pkg.sv
verilog/snd_latch_if.sv
verilog/cpu_irq_request.sv
verilog/main_io_ports.sv
verilog/sound_latch.sv
verilog/sound_io_ports.sv
verilog/arcade_io_top.sv
test/tb_arcade_io.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= filelist.f
TOP       ?= tb_arcade_io
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --timescale 1ns/10ps
JOBS      ?= 0
PASS_MSG  ?= >>> PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* test/tb_arcade_io.sv */
`timescale 1ns/10ps

module tb_arcade_io;

  localparam int CLK_PERIOD = 100;
  localparam int TIMER_DIV  = arcade_io_pkg::AUDIO_IRQ_DIV;
  localparam int WATCHDOG_CYCLES = 4 * TIMER_DIV + 200;

  logic clk_sys = 1'b0;
  logic rst;
  arcade_io_pkg::port_t   main_addr;
  arcade_io_pkg::byte_t   main_dout;
  logic                   main_iorq_n;
  logic                   main_m1_n;
  arcade_io_pkg::byte_t   j1;
  arcade_io_pkg::byte_t   j2;
  arcade_io_pkg::byte_t   p1;
  arcade_io_pkg::byte_t   p2;
  arcade_io_pkg::byte_t   system;
  logic                   vs;
  arcade_io_pkg::byte_t   main_io_data;
  logic                   main_int_n;
  arcade_io_pkg::scroll_t scrollx;
  arcade_io_pkg::scroll_t scrolly;
  arcade_io_pkg::layers_t layers;
  logic                   bank;
  logic                   flip;
  arcade_io_pkg::port_t   snd_addr;
  arcade_io_pkg::byte_t   snd_dout;
  logic                   snd_iorq_n;
  logic                   snd_m1_n;
  arcade_io_pkg::sample_t ym_sample;
  arcade_io_pkg::byte_t   snd_io_data;
  logic                   snd_int_n;
  logic                   ym_cs;
  logic                   ym_a0;
  arcade_io_pkg::sample_t sound;

  int unsigned checks = 0;
  int unsigned errors = 0;
  int unsigned cyc;
  logic        cs_seen;
  logic        a0_seen;

  arcade_io_top uut (.*);

  always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

  // clocks since reset release
  always @(posedge clk_sys) begin
    if (rst) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  task automatic check_value(input string name, input int unsigned expected,
                             input int unsigned actual);
    checks++;
    assert (expected == actual) else begin
      errors++;
      $display("Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
    end
  endtask

  // one clock i/o cycle on the main bus from falling edge to falling edge
  task automatic main_cycle(input arcade_io_pkg::port_t a, input arcade_io_pkg::byte_t d);
    main_addr   = a;
    main_dout   = d;
    main_iorq_n = 1'b0;
    main_m1_n   = 1'b1;
    @(negedge clk_sys);
    main_iorq_n = 1'b1;
  endtask

  task automatic audio_cycle(input arcade_io_pkg::port_t a, input arcade_io_pkg::byte_t d);
    snd_addr   = a;
    snd_dout   = d;
    snd_iorq_n = 1'b0;
    snd_m1_n   = 1'b1;
    @(posedge clk_sys);
    cs_seen = ym_cs;
    a0_seen = ym_a0;
    @(negedge clk_sys);
    snd_iorq_n = 1'b1;
  endtask

  task automatic acknowledge(input bit audio_bus);
    if (audio_bus) begin
      snd_iorq_n = 1'b0;
      snd_m1_n   = 1'b0;
    end else begin
      main_iorq_n = 1'b0;
      main_m1_n   = 1'b0;
    end
    @(negedge clk_sys);
    {main_iorq_n, main_m1_n, snd_iorq_n, snd_m1_n} = 4'b1111;
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d clocks, run did not finish", WATCHDOG_CYCLES);
    $display("checks: %0d, errors: %0d", checks, errors + 1);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    arcade_io_pkg::byte_t   b [5];
    arcade_io_pkg::byte_t   v;
    arcade_io_pkg::sample_t exp_sound;
    int unsigned            waited;
    void'($urandom(32'h566b));
    rst = 1'b1;
    {main_addr, main_dout, snd_addr, snd_dout} = '0;
    {main_iorq_n, main_m1_n, snd_iorq_n, snd_m1_n} = 4'b1111;
    {j1, j2, p1, p2, system} = '0;
    vs = 1'b1;
    ym_sample = '0;
    repeat (5) @(posedge clk_sys);
    @(negedge clk_sys);
    rst = 1'b0;
    check_value("main_int_n", 1, 32'(main_int_n));
    check_value("snd_int_n", 1, 32'(snd_int_n));
    check_value("sound", 0, 32'(sound));
    check_value("scrollx", 0, 32'(scrollx));

    // main reads
    j1 = 8'($urandom);
    j2 = 8'($urandom);
    system = 8'($urandom);
    p1 = 8'($urandom);
    p2 = 8'($urandom);
    main_cycle(arcade_io_pkg::PORT_J1, 8'h00);
    check_value("main_io_data", 32'(j1), 32'(main_io_data));
    main_cycle(arcade_io_pkg::PORT_J2, 8'h00);
    check_value("main_io_data", 32'(j2), 32'(main_io_data));
    main_cycle(arcade_io_pkg::PORT_SYSTEM, 8'h00);
    check_value("main_io_data", 32'(system), 32'(main_io_data));
    main_cycle(arcade_io_pkg::PORT_P1, 8'h00);
    check_value("main_io_data", 32'(p1), 32'(main_io_data));
    main_cycle(arcade_io_pkg::PORT_P2, 8'h00);
    check_value("main_io_data", 32'(p2), 32'(main_io_data));
    main_cycle(arcade_io_pkg::PORT_BOARD_ID, 8'h00);
    check_value("main_io_data", 32'h58, 32'(main_io_data));

    // control writes to ports 40 to 44
    for (int i = 0; i < 5; i++) begin
      b[i] = 8'($urandom);
      main_cycle(arcade_io_pkg::port_t'('h40 + i), b[i]);
    end
    check_value("bank", 32'(b[0][7]), 32'(bank));
    check_value("flip", 32'(b[0][2]), 32'(flip));
    check_value("scrollx", 32'({b[2][2:0], b[1]}), 32'(scrollx));
    check_value("layers", 32'(b[2][7:5]), 32'(layers));
    check_value("scrolly", 32'({b[4][2:0], b[3]}), 32'(scrolly));

    // command handoff and clear
    v = 8'($urandom);
    main_cycle(arcade_io_pkg::PORT_SND_CMD, v);
    audio_cycle(arcade_io_pkg::PORT_SND_READ, 8'h00);
    check_value("snd_io_data", 32'({v[6:0], 1'b1}), 32'(snd_io_data));
    audio_cycle(arcade_io_pkg::PORT_SND_CLEAR, 8'h00);
    repeat (2) @(negedge clk_sys);
    audio_cycle(arcade_io_pkg::PORT_SND_READ, 8'h00);
    check_value("snd_io_data", 0, 32'(snd_io_data));

    // fm select and mix
    audio_cycle(8'h00, 8'($urandom));
    check_value("ym_cs", 1, 32'(cs_seen));
    check_value("ym_a0", 0, 32'(a0_seen));
    audio_cycle(8'h01, 8'($urandom));
    check_value("ym_cs", 1, 32'(cs_seen));
    check_value("ym_a0", 1, 32'(a0_seen));
    b[0] = 8'($urandom);
    b[1] = 8'($urandom);
    audio_cycle(arcade_io_pkg::PORT_DAC1, b[0]);
    check_value("ym_cs", 0, 32'(cs_seen));
    audio_cycle(arcade_io_pkg::PORT_DAC2, b[1]);
    check_value("ym_cs", 0, 32'(cs_seen));
    ym_sample = 16'($urandom);
    exp_sound = 16'((32'(ym_sample) + 32'(b[0]) * 32 + 32'(b[1]) * 32) % 65536);
    @(negedge clk_sys);
    check_value("sound", 32'(exp_sound), 32'(sound));

    // vertical blank irq
    vs = 1'b0;
    waited = 0;
    while (main_int_n && waited < 2) begin
      @(negedge clk_sys);
      waited++;
    end
    assert (!main_int_n) else begin
      errors++;
      $display("main_int_n did not go low within two clocks of vs falling");
    end
    repeat (3) begin
      @(negedge clk_sys);
      check_value("main_int_n", 0, 32'(main_int_n));
    end
    vs = 1'b1;
    acknowledge(1'b0);
    check_value("main_int_n", 1, 32'(main_int_n));

    // audio timer irq from reset release and again after an ack
    while (snd_int_n && cyc < TIMER_DIV + 2) @(negedge clk_sys);
    assert (!snd_int_n) else begin
      errors++;
      $display("snd_int_n did not go low within %0d clocks of reset release", TIMER_DIV + 2);
    end
    acknowledge(1'b1);
    check_value("snd_int_n", 1, 32'(snd_int_n));
    waited = 0;
    while (snd_int_n && waited < TIMER_DIV + 2) begin
      @(negedge clk_sys);
      waited++;
    end
    assert (!snd_int_n) else begin
      errors++;
      $display("snd_int_n did not go low again within %0d clocks of the ack", TIMER_DIV + 2);
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* verilog/arcade_io_top.sv */
`timescale 1ns/10ps

module arcade_io_top (
  input  logic                   clk_sys,
  input  logic                   rst,
  input  arcade_io_pkg::port_t   main_addr,
  input  arcade_io_pkg::byte_t   main_dout,
  input  logic                   main_iorq_n,
  input  logic                   main_m1_n,
  input  arcade_io_pkg::byte_t   j1,
  input  arcade_io_pkg::byte_t   j2,
  input  arcade_io_pkg::byte_t   p1,
  input  arcade_io_pkg::byte_t   p2,
  input  arcade_io_pkg::byte_t   system,
  input  logic                   vs,
  output arcade_io_pkg::byte_t   main_io_data,
  output logic                   main_int_n,
  output arcade_io_pkg::scroll_t scrollx,
  output arcade_io_pkg::scroll_t scrolly,
  output arcade_io_pkg::layers_t layers,
  output logic                   bank,
  output logic                   flip,
  input  arcade_io_pkg::port_t   snd_addr,
  input  arcade_io_pkg::byte_t   snd_dout,
  input  logic                   snd_iorq_n,
  input  logic                   snd_m1_n,
  input  arcade_io_pkg::sample_t ym_sample,
  output arcade_io_pkg::byte_t   snd_io_data,
  output logic                   snd_int_n,
  output logic                   ym_cs,
  output logic                   ym_a0,
  output arcade_io_pkg::sample_t sound
);

  snd_latch_if latch_bus ();

  main_io_ports main_io (
    .clk_sys (clk_sys),
    .rst     (rst),
    .addr    (main_addr),
    .dout    (main_dout),
    .iorq_n  (main_iorq_n),
    .m1_n    (main_m1_n),
    .j1      (j1),
    .j2      (j2),
    .p1      (p1),
    .p2      (p2),
    .system  (system),
    .io_data (main_io_data),
    .scrollx (scrollx),
    .scrolly (scrolly),
    .layers  (layers),
    .bank    (bank),
    .flip    (flip),
    .latch   (latch_bus.host)
  );

  // irq on the falling edge of vsync
  cpu_irq_request vblank_irq (
    .clk_sys (clk_sys),
    .rst     (rst),
    .trigger (~vs),
    .iorq_n  (main_iorq_n),
    .m1_n    (main_m1_n),
    .int_n   (main_int_n)
  );

  sound_latch cmd_latch (
    .clk_sys (clk_sys),
    .rst     (rst),
    .latch   (latch_bus.latch)
  );

  sound_io_ports snd_io (
    .clk_sys   (clk_sys),
    .rst       (rst),
    .addr      (snd_addr),
    .dout      (snd_dout),
    .iorq_n    (snd_iorq_n),
    .m1_n      (snd_m1_n),
    .ym_sample (ym_sample),
    .io_data   (snd_io_data),
    .ym_cs     (ym_cs),
    .ym_a0     (ym_a0),
    .int_n     (snd_int_n),
    .sound     (sound),
    .latch     (latch_bus.sound)
  );

endmodule

/* verilog/sound_io_ports.sv */
`timescale 1ns/10ps

module sound_io_ports (
  input  logic                   clk_sys,
  input  logic                   rst,
  input  arcade_io_pkg::port_t   addr,
  input  arcade_io_pkg::byte_t   dout,
  input  logic                   iorq_n,
  input  logic                   m1_n,
  input  arcade_io_pkg::sample_t ym_sample,
  output arcade_io_pkg::byte_t   io_data,
  output logic                   ym_cs,
  output logic                   ym_a0,
  output logic                   int_n,
  output arcade_io_pkg::sample_t sound,
  snd_latch_if.sound             latch
);

  logic                   io_cyc;
  logic                   tick;
  arcade_io_pkg::timer_t  tick_cnt;
  arcade_io_pkg::byte_t   dac1;
  arcade_io_pkg::byte_t   dac2;
  arcade_io_pkg::sample_t dac1_mix;
  arcade_io_pkg::sample_t dac2_mix;

  assign io_cyc = ~iorq_n & m1_n;

  // fm chip decodes ports 00 and 01
  assign ym_cs = io_cyc & ({addr[7:1], 1'b0} == arcade_io_pkg::PORT_FM_BASE);
  assign ym_a0 = addr[0];

  always_ff @(posedge clk_sys) begin
    if (rst) begin
      io_data   <= '0;
      dac1      <= '0;
      dac2      <= '0;
      latch.clr <= 1'b0;
    end else begin
      latch.clr <= io_cyc & (addr == arcade_io_pkg::PORT_SND_CLEAR);
      if (io_cyc) begin
        case (addr)
          arcade_io_pkg::PORT_DAC1: begin
            dac1 <= dout;
          end
          arcade_io_pkg::PORT_DAC2: begin
            dac2 <= dout;
          end
          arcade_io_pkg::PORT_SND_READ: begin
            io_data <= latch.q;
          end
          default: begin
          end
        endcase
      end
    end
  end

  // free running period counter for the audio irq
  assign tick = (tick_cnt == arcade_io_pkg::TIMER_LAST);

  always_ff @(posedge clk_sys) begin
    if (rst) begin
      tick_cnt <= '0;
    end else if (tick) begin
      tick_cnt <= '0;
    end else begin
      tick_cnt <= tick_cnt + 1'b1;
    end
  end

  cpu_irq_request timer_irq (
    .clk_sys (clk_sys),
    .rst     (rst),
    .trigger (tick),
    .iorq_n  (iorq_n),
    .m1_n    (m1_n),
    .int_n   (int_n)
  );

  assign dac1_mix = arcade_io_pkg::sample_t'(dac1) << arcade_io_pkg::DAC_SHIFT;
  assign dac2_mix = arcade_io_pkg::sample_t'(dac2) << arcade_io_pkg::DAC_SHIFT;

  // sum wraps at 16 bits
  always_ff @(posedge clk_sys) begin
    if (rst) begin
      sound <= '0;
    end else begin
      sound <= ym_sample + dac1_mix + dac2_mix;
    end
  end

endmodule

/* verilog/sound_latch.sv */
`timescale 1ns/10ps

module sound_latch (
  input  logic       clk_sys,
  input  logic       rst,
  snd_latch_if.latch latch
);

  arcade_io_pkg::byte_t cmd;

  // write from the main cpu wins over a clear
  always_ff @(posedge clk_sys) begin
    if (rst) begin
      cmd <= '0;
    end else if (latch.wr) begin
      cmd <= latch.wr_data;
    end else if (latch.clr) begin
      cmd <= '0;
    end
  end

  assign latch.q = cmd;

endmodule

/* verilog/main_io_ports.sv */
`timescale 1ns/10ps

module main_io_ports (
  input  logic                   clk_sys,
  input  logic                   rst,
  input  arcade_io_pkg::port_t   addr,
  input  arcade_io_pkg::byte_t   dout,
  input  logic                   iorq_n,
  input  logic                   m1_n,
  input  arcade_io_pkg::byte_t   j1,
  input  arcade_io_pkg::byte_t   j2,
  input  arcade_io_pkg::byte_t   p1,
  input  arcade_io_pkg::byte_t   p2,
  input  arcade_io_pkg::byte_t   system,
  output arcade_io_pkg::byte_t   io_data,
  output arcade_io_pkg::scroll_t scrollx,
  output arcade_io_pkg::scroll_t scrolly,
  output arcade_io_pkg::layers_t layers,
  output logic                   bank,
  output logic                   flip,
  snd_latch_if.host              latch
);

  logic io_cyc;

  // plain i/o cycle rather than an interrupt ack
  assign io_cyc = ~iorq_n & m1_n;

  // bit 0 flags a pending command for the audio side
  assign latch.wr      = io_cyc & (addr == arcade_io_pkg::PORT_SND_CMD);
  assign latch.wr_data = {dout[6:0], 1'b1};

  always_ff @(posedge clk_sys) begin
    if (rst) begin
      io_data <= '0;
      scrollx <= '0;
      scrolly <= '0;
      layers  <= '0;
      bank    <= 1'b0;
      flip    <= 1'b0;
    end else if (io_cyc) begin
      case (addr)
        arcade_io_pkg::PORT_J1: begin
          io_data <= j1;
        end
        arcade_io_pkg::PORT_J2: begin
          io_data <= j2;
        end
        arcade_io_pkg::PORT_SYSTEM: begin
          io_data <= system;
        end
        arcade_io_pkg::PORT_P1: begin
          io_data <= p1;
        end
        arcade_io_pkg::PORT_P2: begin
          io_data <= p2;
        end
        arcade_io_pkg::PORT_BOARD_ID: begin
          io_data <= arcade_io_pkg::BOARD_ID;
        end
        arcade_io_pkg::PORT_BANK_FLIP: begin
          bank <= dout[7];
          flip <= dout[2];
        end
        arcade_io_pkg::PORT_SCROLLX_LO: begin
          scrollx[7:0] <= dout;
        end
        arcade_io_pkg::PORT_SCROLLX_HI: begin
          // layer enables share this port with the scroll msbs
          layers        <= dout[7:5];
          scrollx[10:8] <= dout[2:0];
        end
        arcade_io_pkg::PORT_SCROLLY_LO: begin
          scrolly[7:0] <= dout;
        end
        arcade_io_pkg::PORT_SCROLLY_HI: begin
          scrolly[10:8] <= dout[2:0];
        end
        default: begin
        end
      endcase
    end
  end

endmodule

/* verilog/cpu_irq_request.sv */
`timescale 1ns/10ps

module cpu_irq_request (
  input  logic clk_sys,
  input  logic rst,
  input  logic trigger,
  input  logic iorq_n,
  input  logic m1_n,
  output logic int_n
);

  logic trigger_q;
  logic ack;

  // z80 acknowledges with iorq and m1 both low
  assign ack = ~iorq_n & ~m1_n;

  always_ff @(posedge clk_sys) begin
    if (rst) begin
      trigger_q <= 1'b0;
      int_n     <= 1'b1;
    end else begin
      trigger_q <= trigger;
      // a new request beats a pending ack
      if (trigger & ~trigger_q) begin
        int_n <= 1'b0;
      end else if (ack) begin
        int_n <= 1'b1;
      end
    end
  end

endmodule

/* verilog/snd_latch_if.sv */
`timescale 1ns/10ps

// sound command path between the two cpus
interface snd_latch_if;

  logic                 wr;
  arcade_io_pkg::byte_t wr_data;
  arcade_io_pkg::byte_t q;
  logic                 clr;

  modport host (
    output wr,
    output wr_data
  );

  modport sound (
    output clr,
    input  q
  );

  modport latch (
    input  wr,
    input  wr_data,
    input  clr,
    output q
  );

endinterface

/* verilog/arcade_io_pkg.sv */
package arcade_io_pkg;

  // bus and register widths
  typedef logic [7:0]  byte_t;
  typedef logic [7:0]  port_t;
  typedef logic [10:0] scroll_t;
  typedef logic [2:0]  layers_t;
  typedef logic [15:0] sample_t;

  // main cpu ports
  localparam port_t PORT_J1         = 8'h00;
  localparam port_t PORT_J2         = 8'h01;
  localparam port_t PORT_SYSTEM     = 8'h02;
  localparam port_t PORT_P1         = 8'h03;
  localparam port_t PORT_P2         = 8'h04;
  localparam port_t PORT_BANK_FLIP  = 8'h40;
  localparam port_t PORT_SCROLLX_LO = 8'h41;
  localparam port_t PORT_SCROLLX_HI = 8'h42;
  localparam port_t PORT_SCROLLY_LO = 8'h43;
  localparam port_t PORT_SCROLLY_HI = 8'h44;
  localparam port_t PORT_SND_CMD    = 8'h45;
  localparam port_t PORT_BOARD_ID   = 8'hc0;

  // audio cpu ports with the fm chip on 00 and 01
  localparam port_t PORT_FM_BASE    = 8'h00;
  localparam port_t PORT_DAC1       = 8'h02;
  localparam port_t PORT_DAC2       = 8'h03;
  localparam port_t PORT_SND_CLEAR  = 8'h04;
  localparam port_t PORT_SND_READ   = 8'h06;

  localparam byte_t BOARD_ID = 8'h58;

  // each dac lands 5 bits up in the mix
  localparam int DAC_SHIFT = 5;

  // audio timer period in clk_sys cycles
  localparam int AUDIO_IRQ_DIV = 6400;
  localparam int TIMER_W       = $clog2(AUDIO_IRQ_DIV);

  typedef logic [TIMER_W-1:0] timer_t;

  localparam timer_t TIMER_LAST = timer_t'(AUDIO_IRQ_DIV - 1);

endpackage
